// File: clockGen.sv
module clockGen (
	output logic Clk,
	output logic rst
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		Clk = 1'b0;
		forever #10 Clk = ~Clk; // 20 ns period
	end

	initial begin
		rst = 1'b1;
		repeat (5) @(posedge Clk);
		rst <= 1'b0;
	end

endmodule

// File: decodeStage.sv
`include "mips_defines.svh"

module decodeStage (
	input  logic Clk,
	input  logic rst,
	input  logic stall,
	input  logic flushIdEx,
	input  mipsPkg::word_t ifIdPc,
	input  mipsPkg::word_t ifIdInstr,
	input  mipsPkg::word_t rsData,
	input  mipsPkg::word_t rtData,
	output mipsPkg::regAddr_t rsAddr,
	output mipsPkg::regAddr_t rtAddr,
	output logic jumpTaken,
	output mipsPkg::word_t jumpTarget,
	output mipsPkg::idEx_t idEx
);
	import mipsPkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;
	logic zeroExt;
	ctrl_t ctrl;
	word_t pcPlus4;
	word_t imm;
	regAddr_t dest;

	assign opcode = ifIdInstr[31:26];
	assign funct = ifIdInstr[5:0];
	assign rsAddr = ifIdInstr[25:21];
	assign rtAddr = ifIdInstr[20:16];
	assign pcPlus4 = ifIdPc + 32'd4;

	assign jumpTaken = opcode == `OPC_J;
	assign jumpTarget = {pcPlus4[`WORD_W-1:28], ifIdInstr[25:0], 2'b00};

	assign imm = zeroExt ? {{(`WORD_W-16){1'b0}}, ifIdInstr[15:0]}
		: {{(`WORD_W-16){ifIdInstr[15]}}, ifIdInstr[15:0]};
	assign dest = (opcode == `OPC_RTYPE) ? ifIdInstr[15:11] : ifIdInstr[20:16];

	always_comb begin
		ctrl = '0;
		zeroExt = 1'b0;
		case (opcode)
			`OPC_RTYPE: begin
				ctrl.regWrite = 1'b1;
				case (funct)
					`FN_ADDU: ctrl.aluOp = ALU_ADD;
					`FN_SUBU: ctrl.aluOp = ALU_SUB;
					`FN_AND:  ctrl.aluOp = ALU_AND;
					`FN_OR:   ctrl.aluOp = ALU_OR;
					`FN_SLT:  ctrl.aluOp = ALU_SLT;
					default:  ctrl.regWrite = 1'b0; // Also catches the zero word
				endcase
			end
			`OPC_ADDIU: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.aluOp = ALU_ADD;
			end
			`OPC_ORI: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.aluOp = ALU_OR;
				zeroExt = 1'b1; // Logical immediate
			end
			`OPC_LW: begin
				ctrl.regWrite = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.aluOp = ALU_ADD;
			end
			`OPC_SW: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.aluOp = ALU_ADD;
			end
			`OPC_BEQ: begin
				ctrl.branch = 1'b1;
				ctrl.aluOp = ALU_SUB;
			end
			default: ; // J and unknown opcodes go down as bubbles
		endcase
	end

	always_ff @(posedge Clk) begin
		if (rst || stall || flushIdEx)
			idEx.ctrl <= '0;
		else
			idEx.ctrl <= ctrl;
		idEx.pcPlus4 <= pcPlus4;
		idEx.rsData <= rsData;
		idEx.rtData <= rtData;
		idEx.imm <= imm;
		idEx.rs <= rsAddr;
		idEx.rt <= rtAddr;
		idEx.dest <= dest;
	end

endmodule

// File: executeStage.sv
module executeStage (
	input  logic Clk,
	input  logic rst,
	input  mipsPkg::idEx_t idEx,
	input  mipsPkg::fwdSel_e fwdA,
	input  mipsPkg::fwdSel_e fwdB,
	input  mipsPkg::word_t wbData,
	output logic branchTaken,
	output mipsPkg::word_t branchTarget,
	output mipsPkg::exMem_t exMem
);
	import mipsPkg::*;

	word_t opA;
	word_t rtFwd;
	word_t opB;
	word_t aluResult;

	function automatic word_t fwdMux(fwdSel_e sel, word_t regVal, word_t memVal, word_t wbVal);
		case (sel)
			FWD_MEM: return memVal;
			FWD_WB:  return wbVal;
			default: return regVal;
		endcase
	endfunction

	assign opA = fwdMux(fwdA, idEx.rsData, exMem.aluResult, wbData);
	assign rtFwd = fwdMux(fwdB, idEx.rtData, exMem.aluResult, wbData); // Also the store data
	assign opB = idEx.ctrl.aluSrcImm ? idEx.imm : rtFwd;

	always_comb begin
		case (idEx.ctrl.aluOp)
			ALU_SUB: aluResult = opA - opB;
			ALU_AND: aluResult = opA & opB;
			ALU_OR:  aluResult = opA | opB;
			ALU_SLT: aluResult = word_t'($signed(opA) < $signed(opB));
			default: aluResult = opA + opB;
		endcase
	end

	// BEQ resolved here, not taken is assumed up front
	assign branchTaken = idEx.ctrl.branch && (opA == rtFwd);
	assign branchTarget = idEx.pcPlus4 + (idEx.imm << 2);

	always_ff @(posedge Clk) begin
		if (rst) begin
			exMem.regWrite <= 1'b0;
			exMem.memRead <= 1'b0;
			exMem.memWrite <= 1'b0;
			exMem.memToReg <= 1'b0;
		end else begin
			exMem.regWrite <= idEx.ctrl.regWrite;
			exMem.memRead <= idEx.ctrl.memRead;
			exMem.memWrite <= idEx.ctrl.memWrite;
			exMem.memToReg <= idEx.ctrl.memToReg;
		end
		exMem.aluResult <= aluResult;
		exMem.storeData <= rtFwd;
		exMem.dest <= idEx.dest;
	end

endmodule

// File: fetchStage.sv
`include "mips_defines.svh"

module fetchStage (
	input  logic Clk,
	input  logic rst,
	input  logic stall,
	input  logic flushIfId,
	input  logic jumpTaken,
	input  mipsPkg::word_t jumpTarget,
	input  logic branchTaken,
	input  mipsPkg::word_t branchTarget,
	input  mipsPkg::word_t imemData,
	output mipsPkg::word_t imemAddr,
	output mipsPkg::word_t ifIdPc,
	output mipsPkg::word_t ifIdInstr
);
	import mipsPkg::*;

	word_t pc;
	word_t pcPlus4;

	assign imemAddr = pc;
	assign pcPlus4 = pc + 32'd4;

	// Branch in EX is older than a jump in ID
	always_ff @(posedge Clk) begin
		if (rst)
			pc <= `RESET_PC;
		else if (branchTaken)
			pc <= branchTarget;
		else if (jumpTaken)
			pc <= jumpTarget;
		else if (!stall)
			pc <= pcPlus4;
	end

	always_ff @(posedge Clk) begin
		if (rst || flushIfId) begin
			ifIdInstr <= '0; // Zero word decodes as a bubble
			ifIdPc <= '0;
		end else if (!stall) begin
			ifIdInstr <= imemData;
			ifIdPc <= pc;
		end
	end

	// Both target paths must keep the fetch address on a word boundary
	assert property (@(posedge Clk) disable iff (rst) imemAddr[1:0] == 2'b00);

endmodule

// File: hazardUnit.sv
`include "mips_defines.svh"

module hazardUnit (
	input  mipsPkg::word_t ifIdInstr,
	input  mipsPkg::idEx_t idEx,
	input  mipsPkg::exMem_t exMem,
	input  logic wbEn,
	input  mipsPkg::regAddr_t wbDest,
	input  logic branchTaken,
	output mipsPkg::fwdSel_e fwdA,
	output mipsPkg::fwdSel_e fwdB,
	output logic stall,
	output logic flushIfId,
	output logic flushIdEx
);
	import mipsPkg::*;

	logic [5:0] opcode;
	regAddr_t idRs;
	regAddr_t idRt;
	logic usesRs;
	logic usesRt;
	logic loadUse;

	// Youngest producer wins
	function automatic fwdSel_e pickFwd(regAddr_t src, exMem_t mem, logic wEn, regAddr_t wDest);
		if (mem.regWrite && mem.dest != '0 && mem.dest == src)
			return FWD_MEM;
		if (wEn && wDest != '0 && wDest == src)
			return FWD_WB;
		return FWD_NONE;
	endfunction

	assign fwdA = pickFwd(idEx.rs, exMem, wbEn, wbDest);
	assign fwdB = pickFwd(idEx.rt, exMem, wbEn, wbDest);

	assign opcode = ifIdInstr[31:26];
	assign idRs = ifIdInstr[25:21];
	assign idRt = ifIdInstr[20:16];
	assign usesRs = opcode != `OPC_J; // J index bits are not registers
	assign usesRt = opcode inside {`OPC_RTYPE, `OPC_SW, `OPC_BEQ};

	assign loadUse = idEx.ctrl.memRead && idEx.dest != '0
		&& ((usesRs && idEx.dest == idRs) || (usesRt && idEx.dest == idRt));

	assign stall = loadUse && !branchTaken;
	assign flushIdEx = branchTaken;
	assign flushIfId = branchTaken || opcode == `OPC_J;

	// Decode never marks one instruction as both load and branch
	always_comb begin
		assert final (!(loadUse && branchTaken));
	end

endmodule

// File: memWbStage.sv
module memWbStage (
	input  logic Clk,
	input  logic rst,
	input  mipsPkg::exMem_t exMem,
	input  mipsPkg::word_t dmemReadData,
	output mipsPkg::word_t dmemAddr,
	output mipsPkg::word_t dmemWriteData,
	output logic dmemRead,
	output logic dmemWrite,
	output logic wbEn,
	output mipsPkg::regAddr_t wbDest,
	output mipsPkg::word_t wbData
);
	import mipsPkg::*;

	memWb_t memWb;

	assign dmemAddr = exMem.aluResult;
	assign dmemWriteData = exMem.storeData;
	assign dmemRead = exMem.memRead;
	assign dmemWrite = exMem.memWrite;

	always_ff @(posedge Clk) begin
		if (rst) begin
			memWb.regWrite <= 1'b0;
			memWb.memToReg <= 1'b0;
		end else begin
			memWb.regWrite <= exMem.regWrite;
			memWb.memToReg <= exMem.memToReg;
		end
		memWb.aluResult <= exMem.aluResult;
		memWb.loadData <= dmemReadData; // Memory answers in the same cycle
		memWb.dest <= exMem.dest;
	end

	assign wbEn = memWb.regWrite;
	assign wbDest = memWb.dest;
	assign wbData = memWb.memToReg ? memWb.loadData : memWb.aluResult;

	assert property (@(posedge Clk) disable iff (rst) !(dmemRead && dmemWrite));

endmodule

// File: mipsPipeline.sv
module mipsPipeline (
	input  logic Clk,
	input  logic rst,
	input  mipsPkg::word_t imemData,
	input  mipsPkg::word_t dmemReadData,
	output mipsPkg::word_t imemAddr,
	output mipsPkg::word_t dmemAddr,
	output mipsPkg::word_t dmemWriteData,
	output logic dmemRead,
	output logic dmemWrite
);
	import mipsPkg::*;

	word_t ifIdPc, ifIdInstr;
	word_t jumpTarget, branchTarget;
	word_t rsData, rtData, wbData;
	regAddr_t rsAddr, rtAddr, wbDest;
	logic jumpTaken, branchTaken, wbEn;
	logic stall, flushIfId, flushIdEx;
	fwdSel_e fwdA, fwdB;
	idEx_t idEx;
	exMem_t exMem;

	fetchStage u_fetch (
		.Clk(Clk), .rst(rst), .stall(stall), .flushIfId(flushIfId),
		.jumpTaken(jumpTaken), .jumpTarget(jumpTarget),
		.branchTaken(branchTaken), .branchTarget(branchTarget),
		.imemData(imemData), .imemAddr(imemAddr),
		.ifIdPc(ifIdPc), .ifIdInstr(ifIdInstr)
	);

	decodeStage u_decode (
		.Clk(Clk), .rst(rst), .stall(stall), .flushIdEx(flushIdEx),
		.ifIdPc(ifIdPc), .ifIdInstr(ifIdInstr), .rsData(rsData), .rtData(rtData),
		.rsAddr(rsAddr), .rtAddr(rtAddr),
		.jumpTaken(jumpTaken), .jumpTarget(jumpTarget), .idEx(idEx)
	);

	registerFile u_regFile (
		.Clk(Clk), .rsAddr(rsAddr), .rtAddr(rtAddr),
		.wbEn(wbEn), .wbDest(wbDest), .wbData(wbData),
		.rsData(rsData), .rtData(rtData)
	);

	hazardUnit u_hazard (
		.ifIdInstr(ifIdInstr), .idEx(idEx), .exMem(exMem),
		.wbEn(wbEn), .wbDest(wbDest), .branchTaken(branchTaken),
		.fwdA(fwdA), .fwdB(fwdB),
		.stall(stall), .flushIfId(flushIfId), .flushIdEx(flushIdEx)
	);

	executeStage u_execute (
		.Clk(Clk), .rst(rst), .idEx(idEx), .fwdA(fwdA), .fwdB(fwdB), .wbData(wbData),
		.branchTaken(branchTaken), .branchTarget(branchTarget), .exMem(exMem)
	);

	memWbStage u_memWb (
		.Clk(Clk), .rst(rst), .exMem(exMem), .dmemReadData(dmemReadData),
		.dmemAddr(dmemAddr), .dmemWriteData(dmemWriteData),
		.dmemRead(dmemRead), .dmemWrite(dmemWrite),
		.wbEn(wbEn), .wbDest(wbDest), .wbData(wbData)
	);

endmodule

// File: mipsPkg.sv
`include "mips_defines.svh"

package mipsPkg;

	typedef logic [`WORD_W-1:0] word_t;
	typedef logic [`REG_ADDR_W-1:0] regAddr_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT
	} aluOp_e;

	typedef enum logic [1:0] {
		FWD_NONE,
		FWD_MEM,
		FWD_WB
	} fwdSel_e;

	// All zero is a bubble
	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic memToReg;
		logic aluSrcImm;
		logic branch;
		aluOp_e aluOp;
	} ctrl_t;

	typedef struct packed {
		ctrl_t ctrl;
		word_t pcPlus4;
		word_t rsData;
		word_t rtData;
		word_t imm;
		regAddr_t rs;
		regAddr_t rt;
		regAddr_t dest;
	} idEx_t;

	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic memToReg;
		word_t aluResult;
		word_t storeData;
		regAddr_t dest;
	} exMem_t;

	typedef struct packed {
		logic regWrite;
		logic memToReg;
		word_t aluResult;
		word_t loadData;
		regAddr_t dest;
	} memWb_t;

endpackage

// File: mips_defines.svh
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

`define WORD_W      32
`define REG_ADDR_W  5
`define RESET_PC    32'h0000_0000

// Primary opcodes, instr[31:26]
`define OPC_RTYPE   6'h00
`define OPC_J       6'h02
`define OPC_BEQ     6'h04
`define OPC_ADDIU   6'h09
`define OPC_ORI     6'h0d
`define OPC_LW      6'h23
`define OPC_SW      6'h2b

// R-type function codes, instr[5:0]
`define FN_ADDU     6'h21
`define FN_SUBU     6'h23
`define FN_AND      6'h24
`define FN_OR       6'h25
`define FN_SLT      6'h2a

`endif

// File: registerFile.sv
`include "mips_defines.svh"

module registerFile (
	input  logic Clk,
	input  mipsPkg::regAddr_t rsAddr,
	input  mipsPkg::regAddr_t rtAddr,
	input  logic wbEn,
	input  mipsPkg::regAddr_t wbDest,
	input  mipsPkg::word_t wbData,
	output mipsPkg::word_t rsData,
	output mipsPkg::word_t rtData
);
	import mipsPkg::*;

	word_t regs [1 << `REG_ADDR_W];

	// Same-cycle write is visible to the reader
	function automatic word_t readPort(regAddr_t addr, logic wEn, regAddr_t wDest,
		word_t wData, word_t stored);
		if (addr == '0)
			return '0;
		if (wEn && wDest == addr)
			return wData;
		return stored;
	endfunction

	always_ff @(posedge Clk) begin
		if (wbEn && wbDest != '0)
			regs[wbDest] <= wbData;
	end

	always_comb begin
		rsData = readPort(rsAddr, wbEn, wbDest, wbData, regs[rsAddr]);
		rtData = readPort(rtAddr, wbEn, wbDest, wbData, regs[rtAddr]);
	end

	assert property (@(posedge Clk) wbEn && wbDest == '0 |=> regs[0] === $past(regs[0]));

endmodule

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_mipsPipeline -o simv
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/simv)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "=== PASS ===" <<< "$output"; then
	exit 0
fi
exit 1

// File: tb_mipsPipeline.sv
`include "mips_defines.svh"

module tb_mipsPipeline;
	timeunit 1ns;
	timeprecision 1ps;
	import mipsPkg::*;

	localparam int CYCLE_LIMIT = 48 * 3 + 20;

	logic Clk, genRst, testRst, dutRst;
	word_t imemData, dmemReadData, imemAddr, dmemAddr, dmemWriteData;
	logic dmemRead, dmemWrite;
	word_t imem [256];
	word_t dmem [64];
	word_t prog [64];
	int progLen;
	word_t expAddr[$], expData[$], obsAddr[$], obsData[$];
	word_t expLoads[$], obsLoads[$];
	int testsRun, testsFailed, errors;

	clockGen u_clockGen (.Clk(Clk), .rst(genRst));

	assign dutRst = genRst | testRst;

	mipsPipeline u_mipsPipeline (
		.Clk(Clk), .rst(dutRst), .imemData(imemData), .dmemReadData(dmemReadData),
		.imemAddr(imemAddr), .dmemAddr(dmemAddr), .dmemWriteData(dmemWriteData),
		.dmemRead(dmemRead), .dmemWrite(dmemWrite)
	);

	// Both memories answer in the same cycle
	always_comb imemData = (imemAddr < 32'd1024) ? imem[imemAddr[9:2]] : '0;
	always_comb dmemReadData = dmem[dmemAddr[7:2]];

	always @(posedge Clk) begin
		if (!dutRst && dmemWrite === 1'b1) begin
			dmem[dmemAddr[7:2]] <= dmemWriteData;
			obsAddr.push_back(dmemAddr);
			obsData.push_back(dmemWriteData);
		end
		if (!dutRst && dmemRead === 1'b1)
			obsLoads.push_back(dmemAddr);
	end

	function automatic word_t fillWord(int i);
		return 32'hC3A5_0000 ^ (word_t'(i) * 32'h0101_0107);
	endfunction

	function automatic word_t encR(int rs, int rt, int rd, logic [5:0] fn);
		return {`OPC_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
	endfunction

	function automatic word_t encI(logic [5:0] op, int rs, int rt, logic [15:0] imm);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	function automatic word_t encJ(int index);
		return {`OPC_J, 26'(index)};
	endfunction

	// Instruction-level model, no delay slots
	task automatic runModel();
		word_t r [32];
		word_t m [64];
		word_t ins, a, b, se, ze;
		logic [5:0] op;
		int pc, next, steps;
		foreach (r[i]) r[i] = '0;
		foreach (m[i]) m[i] = fillWord(i);
		expAddr.delete();
		expData.delete();
		expLoads.delete();
		pc = 0;
		steps = 0;
		while (pc != progLen - 1 && steps < 200) begin
			ins = prog[pc];
			op = ins[31:26];
			a = r[ins[25:21]];
			b = r[ins[20:16]];
			se = {{16{ins[15]}}, ins[15:0]};
			ze = {16'd0, ins[15:0]};
			next = pc + 1;
			case (op)
				`OPC_RTYPE: begin
					case (ins[5:0])
						`FN_ADDU: r[ins[15:11]] = a + b;
						`FN_SUBU: r[ins[15:11]] = a - b;
						`FN_AND:  r[ins[15:11]] = a & b;
						`FN_OR:   r[ins[15:11]] = a | b;
						`FN_SLT:  r[ins[15:11]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: ;
					endcase
				end
				`OPC_ADDIU: r[ins[20:16]] = a + se;
				`OPC_ORI: r[ins[20:16]] = a | ze;
				`OPC_LW: begin
					expLoads.push_back(a + se);
					r[ins[20:16]] = m[(a + se) >> 2];
				end
				`OPC_SW: begin
					expAddr.push_back(a + se);
					expData.push_back(b);
					m[(a + se) >> 2] = b;
				end
				`OPC_BEQ: if (a == b) next = pc + 1 + int'($signed(ins[15:0]));
				`OPC_J: next = int'(ins[25:0]);
				default: ;
			endcase
			r[0] = '0;
			pc = next;
			steps++;
		end
	endtask

	task automatic makeRandomProgram();
		logic [5:0] fns [5];
		int n, kind, t, rs, rt;
		fns = '{`FN_ADDU, `FN_SUBU, `FN_AND, `FN_OR, `FN_SLT};
		n = 16 + int'($urandom % 33);
		for (int k = 1; k < 8; k++)
			prog[k - 1] = encI(`OPC_ADDIU, 0, k, 16'($urandom));
		for (int i = 7; i < n - 1; i++) begin
			kind = int'($urandom % 10);
			rs = int'($urandom % 8);
			rt = int'($urandom % 8);
			t = i + 1 + int'($urandom % (n - 1 - i)); // Forward only
			case (kind)
				0, 1, 2: prog[i] = encR(rs, rt, 1 + int'($urandom % 7), fns[$urandom % 5]);
				3: prog[i] = encI(`OPC_ADDIU, rs, 1 + int'($urandom % 7), 16'($urandom));
				4: prog[i] = encI(`OPC_ORI, rs, 1 + int'($urandom % 7), 16'($urandom));
				5: prog[i] = encI(`OPC_LW, 0, 1 + int'($urandom % 7), 16'(($urandom % 64) * 4));
				6, 7: prog[i] = encI(`OPC_SW, 0, rt, 16'(($urandom % 64) * 4));
				8: begin
					if ($urandom % 3 == 0)
						rt = rs; // Forces a taken branch now and then
					prog[i] = encI(`OPC_BEQ, rs, rt, 16'(t - (i + 1)));
				end
				default: prog[i] = encJ(t);
			endcase
		end
		prog[n - 1] = encJ(n - 1);
		progLen = n;
	endtask

	task automatic runTest(string name);
		int cycles;
		int bad;
		foreach (imem[i]) imem[i] = '0;
		for (int i = 0; i < progLen; i++)
			imem[i] = prog[i];
		foreach (dmem[i]) dmem[i] <= fillWord(i);
		runModel();
		obsAddr.delete();
		obsData.delete();
		obsLoads.delete();
		@(posedge Clk);
		testRst <= 1'b1;
		repeat (5) @(posedge Clk);
		testRst <= 1'b0;
		@(negedge Clk);
		bad = 0;
		if (imemAddr !== `RESET_PC || dmemWrite !== 1'b0 || dmemRead !== 1'b0) begin
			$display("[FAIL] %0d ns %s: after reset imemAddr=%h dmemWrite=%b dmemRead=%b",
				$time, name, imemAddr, dmemWrite, dmemRead);
			bad++;
		end
		cycles = 0;
		while (imemAddr !== word_t'((progLen - 1) * 4)) begin
			@(negedge Clk);
			cycles++;
			if (cycles > CYCLE_LIMIT) begin
				$display("%s: timed out, halt address not reached in %0d cycles", name, cycles);
				$display("=== FAIL ===");
				$finish;
			end
		end
		repeat (6) @(negedge Clk); // Drain older instructions
		if (obsAddr.size() != expAddr.size()) begin
			$display("[FAIL] %0d ns %s: %0d stores seen, %0d expected", $time, name,
				obsAddr.size(), expAddr.size());
			bad++;
		end
		for (int i = 0; i < obsAddr.size() && i < expAddr.size(); i++) begin
			if (obsAddr[i] !== expAddr[i] || obsData[i] !== expData[i]) begin
				$display("[FAIL] %0d ns %s: store %0d got %h <= %h, expected %h <= %h", $time,
					name, i, obsAddr[i], obsData[i], expAddr[i], expData[i]);
				bad++;
			end
		end
		if (obsLoads.size() != expLoads.size()) begin
			$display("[FAIL] %0d ns %s: %0d loads seen, %0d expected", $time, name,
				obsLoads.size(), expLoads.size());
			bad++;
		end
		for (int i = 0; i < obsLoads.size() && i < expLoads.size(); i++) begin
			if (obsLoads[i] !== expLoads[i]) begin
				$display("[FAIL] %0d ns %s: load %0d from %h, expected %h", $time,
					name, i, obsLoads[i], expLoads[i]);
				bad++;
			end
		end
		testsRun++;
		errors += bad;
		if (bad > 0)
			testsFailed++;
		$display("%-16s %s  stores=%0d cycles=%0d", name, (bad > 0) ? "failed" : "ok",
			expAddr.size(), cycles);
	endtask

	initial begin
		testRst = 1'b0;
		foreach (imem[i]) imem[i] = '0;
		foreach (dmem[i]) dmem[i] <= '0;
		void'($urandom(53));
		testsRun = 0;
		testsFailed = 0;
		errors = 0;
		wait (genRst == 1'b0);

		prog[0] = encI(`OPC_ADDIU, 0, 1, 16'd1);
		prog[1] = encI(`OPC_ADDIU, 1, 1, 16'd1);
		prog[2] = encI(`OPC_SW, 0, 1, 16'd36);
		prog[3] = encJ(3);
		progLen = 4;
		runTest("reset");

		prog[0] = encI(`OPC_ADDIU, 0, 1, 16'd5);
		prog[1] = encI(`OPC_ADDIU, 1, 2, 16'd7);
		prog[2] = encR(2, 1, 3, `FN_ADDU);
		prog[3] = encR(3, 2, 4, `FN_SUBU);
		prog[4] = encI(`OPC_SW, 0, 4, 16'd0);
		prog[5] = encI(`OPC_SW, 0, 3, 16'd4);
		prog[6] = encJ(6);
		progLen = 7;
		runTest("forwarding");

		prog[0] = encI(`OPC_ADDIU, 0, 1, 16'd9);
		prog[1] = encI(`OPC_SW, 0, 1, 16'd8);
		prog[2] = encI(`OPC_LW, 0, 2, 16'd8);
		prog[3] = encR(2, 1, 3, `FN_ADDU);
		prog[4] = encI(`OPC_SW, 0, 3, 16'd12);
		prog[5] = encJ(5);
		progLen = 6;
		runTest("load-use");

		prog[0] = encI(`OPC_ADDIU, 0, 1, 16'd3);
		prog[1] = encI(`OPC_ADDIU, 0, 2, 16'd3);
		prog[2] = encI(`OPC_BEQ, 1, 2, 16'd1);
		prog[3] = encI(`OPC_SW, 0, 1, 16'd16); // Skipped by the taken branch
		prog[4] = encI(`OPC_BEQ, 1, 0, 16'd1);
		prog[5] = encI(`OPC_SW, 0, 2, 16'd20);
		prog[6] = encJ(6);
		progLen = 7;
		runTest("branch");

		prog[0] = encI(`OPC_ADDIU, 0, 1, 16'd77);
		prog[1] = encJ(4);
		prog[2] = encI(`OPC_SW, 0, 1, 16'd24);
		prog[3] = encI(`OPC_SW, 0, 1, 16'd28);
		prog[4] = encI(`OPC_SW, 0, 1, 16'd32);
		prog[5] = encJ(5);
		progLen = 6;
		runTest("jump");

		for (int k = 0; k < 20; k++) begin
			makeRandomProgram();
			runTest($sformatf("random %0d", k));
		end

		$display("Tests run %0d, failed %0d, mismatches %0d", testsRun, testsFailed, errors);
		if (testsFailed == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: vlog.f
+incdir+.
mipsPkg.sv
fetchStage.sv
registerFile.sv
decodeStage.sv
hazardUnit.sv
executeStage.sv
memWbStage.sv
mipsPipeline.sv
clockGen.sv
tb_mipsPipeline.sv
